//--- design/video_pkg.sv
// video generator shared definitions
// register numbers, pixel depth codes, sync states and the VRAM word types
package video_pkg;

    typedef logic [15:0] vram_word_t;           // VRAM data word and word address

    typedef logic [3:0] reg_num_t;

    localparam reg_num_t REG_DISPSTART  = 4'd0; // frame start word address
    localparam reg_num_t REG_DISPWIDTH  = 4'd1; // words per line stride
    localparam reg_num_t REG_GFXCTRL    = 4'd2; // colorbase, plane disable, bpp
    localparam reg_num_t REG_LINEINTR   = 4'd3; // enable and line number
    localparam reg_num_t REG_R_WIDTH    = 4'd4; // visible width
    localparam reg_num_t REG_R_HEIGHT   = 4'd5; // visible height
    localparam reg_num_t REG_R_SCANLINE = 4'd6; // blank flags and current line

    // codes 0 and 1 are stored as written and scan out as BPP_4
    typedef enum logic [1:0] {
        BPP_4 = 2'd2,
        BPP_8 = 2'd3
    } bpp_t;

    typedef enum logic [1:0] {
        SYNC_PRE,
        SYNC_PULSE,
        SYNC_POST,
        SYNC_VISIBLE
    } sync_state_t;

    // one fetched word, leftmost pixel in the most significant field
    typedef union packed {
        logic [0:3][3:0] nibbles;               // 4-bpp view
        logic [0:1][7:0] bytes;                 // 8-bpp view
    } pixel_word_u;

endpackage

//--- design/video_timing.sv
// raster timing generator
// h/v sync state machines, display enable, line and frame events, interrupt pulses
`timescale 1ns/100ps

module video_timing #(
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int H_VISIBLE  = 640,
    parameter int V_VISIBLE  = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter bit H_SYNC_POL = 1'b0,
    parameter bit V_SYNC_POL = 1'b0
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        enable_i,
    input  logic        line_intr_ena_i,
    input  logic [10:0] line_intr_line_i,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o,
    output logic        vsync_intr_o,
    output logic        vline_intr_o,
    output logic        line_start_o,
    output logic        line_end_o,
    output logic        frame_end_o,
    output logic        vis_line_o,
    output logic        pix_active_o,
    output logic [10:0] v_count_o,
    output logic        h_visible_o,
    output logic        v_visible_o,
    output logic        video_on_o
);
    import video_pkg::*;

    localparam int H_TOTAL = H_FRONT + H_SYNC + H_BACK + H_VISIBLE;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    sync_state_t h_state;
    sync_state_t v_state;
    logic [10:0] h_count;
    logic [10:0] h_limit;                       // last h_count of the current state
    logic [10:0] v_limit;                       // last v_count of the current state
    logic        video_en;

    // blanking sits left of the visible pixels on each line
    always_comb begin
        case (h_state)
            SYNC_PRE:   h_limit = 11'(H_FRONT - 1);
            SYNC_PULSE: h_limit = 11'(H_FRONT + H_SYNC - 1);
            SYNC_POST:  h_limit = 11'(H_FRONT + H_SYNC + H_BACK - 1);
            default:    h_limit = 11'(H_TOTAL - 1);
        endcase
    end

    // and below the visible lines in each frame
    always_comb begin
        case (v_state)
            SYNC_VISIBLE: v_limit = 11'(V_VISIBLE - 1);
            SYNC_PRE:     v_limit = 11'(V_VISIBLE + V_FRONT - 1);
            SYNC_PULSE:   v_limit = 11'(V_VISIBLE + V_FRONT + V_SYNC - 1);
            default:      v_limit = 11'(V_TOTAL - 1);
        endcase
    end

    assign line_start_o = (h_count == 11'd0);
    assign line_end_o   = (h_count == 11'(H_TOTAL - 1));
    assign frame_end_o  = line_end_o && (v_count_o == 11'(V_TOTAL - 1));
    assign h_visible_o  = (h_state == SYNC_VISIBLE);
    assign v_visible_o  = (v_state == SYNC_VISIBLE);
    assign vis_line_o   = v_visible_o;
    assign pix_active_o = v_visible_o && h_visible_o;
    assign video_on_o   = video_en;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count      <= '0;
            v_count_o    <= '0;
            h_state      <= SYNC_PRE;
            v_state      <= SYNC_VISIBLE;
            video_en     <= 1'b0;
            hsync_o      <= ~H_SYNC_POL;
            vsync_o      <= ~V_SYNC_POL;
            dv_de_o      <= 1'b0;
            vsync_intr_o <= 1'b0;
            vline_intr_o <= 1'b0;
        end else begin
            h_count <= line_end_o ? 11'd0 : h_count + 11'd1;
            if (h_count == h_limit) begin
                h_state <= sync_state_t'(h_state + 2'd1);
            end
            if (line_end_o) begin
                v_count_o <= frame_end_o ? 11'd0 : v_count_o + 11'd1;
                if (v_count_o == v_limit) begin
                    v_state <= sync_state_t'(v_state + 2'd1);
                end
            end
            if (frame_end_o) begin
                video_en <= enable_i;           // enable only changes between frames
            end

            hsync_o      <= (h_state == SYNC_PULSE) ? H_SYNC_POL : ~H_SYNC_POL;
            vsync_o      <= (v_state == SYNC_PULSE) ? V_SYNC_POL : ~V_SYNC_POL;
            dv_de_o      <= video_en && pix_active_o;
            vsync_intr_o <= line_end_o && (v_count_o == 11'(V_VISIBLE - 1));
            vline_intr_o <= line_start_o && line_intr_ena_i && (v_count_o == line_intr_line_i);
        end
    end

endmodule

//--- design/video_regs.sv
// control register file
// register writes, registered read-back and the frame-start copy of the start address
`timescale 1ns/100ps

module video_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  reg_wr_i,
    input  video_pkg::reg_num_t   reg_num_i,
    input  video_pkg::vram_word_t reg_data_i,
    input  logic                  frame_end_i,
    input  logic [10:0]           v_count_i,
    input  logic                  h_visible_i,
    input  logic                  v_visible_i,
    output video_pkg::vram_word_t reg_data_o,
    output video_pkg::vram_word_t disp_start_o,
    output video_pkg::vram_word_t line_width_o,
    output logic [7:0]            colorbase_o,
    output logic                  plane_disable_o,
    output video_pkg::bpp_t       bpp_o,
    output logic                  line_intr_ena_o,
    output logic [10:0]           line_intr_line_o
);
    import video_pkg::*;

    vram_word_t start_pend;                     // start address waiting for frame end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_pend       <= '0;
            disp_start_o     <= '0;
            line_width_o     <= 16'(H_VISIBLE / 4);
            colorbase_o      <= '0;
            plane_disable_o  <= 1'b0;
            bpp_o            <= BPP_4;
            line_intr_ena_o  <= 1'b0;
            line_intr_line_o <= '0;
            reg_data_o       <= '0;
        end else begin
            if (reg_wr_i) begin
                case (reg_num_i)
                    REG_DISPSTART: start_pend <= reg_data_i;
                    REG_DISPWIDTH: line_width_o <= reg_data_i;
                    REG_GFXCTRL: begin
                        colorbase_o     <= reg_data_i[15:8];
                        plane_disable_o <= reg_data_i[7];
                        bpp_o           <= bpp_t'(reg_data_i[5:4]);
                    end
                    REG_LINEINTR: begin
                        line_intr_ena_o  <= reg_data_i[15];
                        line_intr_line_o <= reg_data_i[10:0];
                    end
                    default: ;                  // read only or unused
                endcase
            end
            if (frame_end_i) begin
                disp_start_o <= start_pend;
            end

            case (reg_num_i)
                REG_DISPSTART:  reg_data_o <= start_pend;
                REG_DISPWIDTH:  reg_data_o <= line_width_o;
                REG_GFXCTRL:    reg_data_o <= {colorbase_o, plane_disable_o, 1'b0, bpp_o, 4'h0};
                REG_LINEINTR:   reg_data_o <= {line_intr_ena_o, 4'h0, line_intr_line_o};
                REG_R_WIDTH:    reg_data_o <= 16'(H_VISIBLE);
                REG_R_HEIGHT:   reg_data_o <= 16'(V_VISIBLE);
                REG_R_SCANLINE: reg_data_o <= {~v_visible_i, ~h_visible_i, 3'b000, v_count_i};
                default:        reg_data_o <= '0;
            endcase
        end
    end

endmodule

//--- design/vram_fetch.sv
// display memory line fetch
// reads one line of words per visible scan line over a four-phase req/ack handshake
`timescale 1ns/100ps

module vram_fetch #(
    parameter int H_VISIBLE = 640
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  line_start_i,
    input  logic                  line_end_i,
    input  logic                  frame_end_i,
    input  logic                  vis_line_i,
    input  logic                  video_on_i,
    input  logic                  plane_disable_i,
    input  video_pkg::bpp_t       bpp_i,
    input  video_pkg::vram_word_t disp_start_i,
    input  video_pkg::vram_word_t line_width_i,
    input  logic                  vram_ack_i,
    input  video_pkg::vram_word_t vram_data_i,
    input  logic                  fifo_full_i,
    output logic                  vram_req_o,
    output video_pkg::vram_word_t vram_addr_o,
    output logic                  fifo_wr_o,
    output video_pkg::vram_word_t fifo_data_o,
    output logic                  fifo_flush_o
);
    import video_pkg::*;

    localparam int CNT_W = $clog2(H_VISIBLE / 2 + 1);

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,                                  // req high, waiting for ack
        F_RELEASE                               // req low, waiting for ack to drop
    } fetch_state_t;

    fetch_state_t     state;
    vram_word_t       line_addr;
    vram_word_t       rd_addr;
    vram_word_t       line_base;
    logic [CNT_W-1:0] words_left;
    logic             frame_pend;               // next line is the first of a frame
    logic             stale;                    // outstanding read belongs to the last line
    logic             fetch_line;
    logic             capture;

    assign line_base  = frame_pend ? disp_start_i : line_addr;
    assign fetch_line = vis_line_i && video_on_i && !plane_disable_i;
    assign capture    = (state == F_REQ) && vram_ack_i && !stale && !line_start_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= F_IDLE;
            vram_req_o   <= 1'b0;
            words_left   <= '0;
            frame_pend   <= 1'b1;
            stale        <= 1'b0;
            fifo_wr_o    <= 1'b0;
            fifo_flush_o <= 1'b0;
        end else begin
            fifo_wr_o    <= capture;
            fifo_flush_o <= line_start_i;
            case (state)
                F_IDLE: begin
                    if (words_left != '0 && !fifo_full_i && !line_start_i) begin
                        vram_req_o <= 1'b1;
                        state      <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (vram_ack_i) begin
                        vram_req_o <= 1'b0;
                        stale      <= 1'b0;
                        state      <= F_RELEASE;
                    end
                end
                default: begin
                    if (!vram_ack_i) begin
                        state <= F_IDLE;
                    end
                end
            endcase
            if (capture) begin
                words_left <= words_left - 1'b1;
            end
            if (frame_end_i) begin
                frame_pend <= 1'b1;
            end
            if (line_start_i) begin
                frame_pend <= 1'b0;
                stale      <= (state == F_REQ) && !vram_ack_i;
                if (!fetch_line) begin
                    words_left <= '0;
                end else if (bpp_i == BPP_8) begin
                    words_left <= CNT_W'(H_VISIBLE / 2);
                end else begin
                    words_left <= CNT_W'(H_VISIBLE / 4);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE) begin
            vram_addr_o <= rd_addr;             // held while the request is up
        end
        if (capture) begin
            fifo_data_o <= vram_data_i;
            rd_addr     <= rd_addr + 16'd1;
        end
        if (line_end_i && vis_line_i) begin
            line_addr <= line_addr + line_width_i;
        end
        if (line_start_i) begin
            line_addr <= line_base;
            rd_addr   <= line_base;
        end
    end

endmodule

//--- design/line_word_fifo.sv
// line word buffer
// circular FIFO with fall-through read and single-cycle flush
`timescale 1ns/100ps

module line_word_fifo #(
    parameter int FIFO_DEPTH = 320
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  logic                  wr_i,
    input  video_pkg::vram_word_t wr_data_i,
    input  logic                  pop_i,
    output video_pkg::vram_word_t rd_data_o,
    output logic                  empty_o,
    output logic                  full_o
);
    import video_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    vram_word_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o   = (count == '0);
    assign full_o    = (count == CW'(FIFO_DEPTH));
    assign do_wr     = wr_i && !full_o;
    assign do_rd     = pop_i && !empty_o;     // pop on empty is dropped
    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

//--- design/pixel_serializer.sv
// pixel serializer
// unpacks buffered words into 8-bit palette indices, 4 or 8 bits per pixel
`timescale 1ns/100ps

module pixel_serializer (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  pix_active_i,
    input  video_pkg::bpp_t       bpp_i,
    input  logic [7:0]            colorbase_i,
    input  video_pkg::vram_word_t word_i,
    input  logic                  empty_i,
    output logic                  pop_o,
    output logic [7:0]            pal_index_o
);
    import video_pkg::*;

    pixel_word_u word;
    logic [1:0]  slot;                          // pixel position within the word
    logic        last_pix;
    logic [7:0]  pixel;

    assign word     = word_i;
    assign last_pix = (bpp_i == BPP_8) ? slot[0] : (slot == 2'd3);
    assign pop_o    = pix_active_i && last_pix && !empty_i;

    always_comb begin
        if (!pix_active_i || empty_i) begin
            pixel = colorbase_i;                // blank, or memory fell behind
        end else if (bpp_i == BPP_8) begin
            pixel = word.bytes[slot[0]];
        end else begin
            pixel = {colorbase_i[7:4], word.nibbles[slot]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot        <= '0;
            pal_index_o <= '0;
        end else begin
            pal_index_o <= pixel;
            slot        <= (!pix_active_i || last_pix) ? 2'd0 : slot + 2'd1;
        end
    end

endmodule

//--- design/video_gen_top.sv
// bitmap raster video generator
// sync timing, control registers, VRAM line fetch and pixel scanout
`timescale 1ns/100ps

module video_gen_top #(
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int H_VISIBLE  = 640,
    parameter int V_VISIBLE  = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter bit H_SYNC_POL = 1'b0,
    parameter bit V_SYNC_POL = 1'b0,
    parameter int FIFO_DEPTH = H_VISIBLE / 2
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  enable_i,
    input  logic                  reg_wr_i,
    input  video_pkg::reg_num_t   reg_num_i,
    input  video_pkg::vram_word_t reg_data_i,
    output video_pkg::vram_word_t reg_data_o,
    output logic                  vram_req_o,
    output video_pkg::vram_word_t vram_addr_o,
    input  logic                  vram_ack_i,
    input  video_pkg::vram_word_t vram_data_i,
    output logic [7:0]            pal_index_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  dv_de_o,
    output logic                  vsync_intr_o,
    output logic                  vline_intr_o
);
    import video_pkg::*;

    logic        line_start;
    logic        line_end;
    logic        frame_end;
    logic        vis_line;
    logic        pix_active;
    logic        h_visible;
    logic        v_visible;
    logic        video_on;
    logic [10:0] v_count;
    logic        line_intr_ena;
    logic [10:0] line_intr_line;
    vram_word_t  disp_start;
    vram_word_t  line_width;
    logic [7:0]  colorbase;
    logic        plane_disable;
    bpp_t        bpp;
    logic        fifo_wr;
    logic        fifo_flush;
    logic        fifo_pop;
    logic        fifo_empty;
    logic        fifo_full;
    vram_word_t  fifo_wdata;
    vram_word_t  fifo_rdata;

    video_timing #(
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK), .H_VISIBLE(H_VISIBLE),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
    ) timing_i (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i),
        .line_intr_ena_i(line_intr_ena), .line_intr_line_i(line_intr_line),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o),
        .vsync_intr_o(vsync_intr_o), .vline_intr_o(vline_intr_o),
        .line_start_o(line_start), .line_end_o(line_end), .frame_end_o(frame_end),
        .vis_line_o(vis_line), .pix_active_o(pix_active), .v_count_o(v_count),
        .h_visible_o(h_visible), .v_visible_o(v_visible), .video_on_o(video_on)
    );

    video_regs #(
        .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)
    ) regs_i (
        .clk(clk), .reset_i(reset_i), .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .frame_end_i(frame_end), .v_count_i(v_count),
        .h_visible_i(h_visible), .v_visible_i(v_visible), .reg_data_o(reg_data_o),
        .disp_start_o(disp_start), .line_width_o(line_width), .colorbase_o(colorbase),
        .plane_disable_o(plane_disable), .bpp_o(bpp),
        .line_intr_ena_o(line_intr_ena), .line_intr_line_o(line_intr_line)
    );

    vram_fetch #(
        .H_VISIBLE(H_VISIBLE)
    ) fetch_i (
        .clk(clk), .reset_i(reset_i), .line_start_i(line_start), .line_end_i(line_end),
        .frame_end_i(frame_end), .vis_line_i(vis_line), .video_on_i(video_on),
        .plane_disable_i(plane_disable), .bpp_i(bpp), .disp_start_i(disp_start),
        .line_width_i(line_width), .vram_ack_i(vram_ack_i), .vram_data_i(vram_data_i),
        .fifo_full_i(fifo_full), .vram_req_o(vram_req_o), .vram_addr_o(vram_addr_o),
        .fifo_wr_o(fifo_wr), .fifo_data_o(fifo_wdata), .fifo_flush_o(fifo_flush)
    );

    line_word_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_i (
        .clk(clk), .reset_i(reset_i), .flush_i(fifo_flush), .wr_i(fifo_wr),
        .wr_data_i(fifo_wdata), .pop_i(fifo_pop), .rd_data_o(fifo_rdata),
        .empty_o(fifo_empty), .full_o(fifo_full)
    );

    pixel_serializer serializer_i (
        .clk(clk), .reset_i(reset_i), .pix_active_i(pix_active), .bpp_i(bpp),
        .colorbase_i(colorbase), .word_i(fifo_rdata), .empty_i(fifo_empty),
        .pop_o(fifo_pop), .pal_index_o(pal_index_o)
    );

endmodule

//--- verif/video_gen_tb.sv
// testbench for the bitmap video generator
// small screen timing, VRAM responder with random latency, directed tests
`timescale 1ns/100ps

module video_gen_tb;
    import video_pkg::*;

    localparam int H_FRONT        = 8;
    localparam int H_SYNC         = 8;
    localparam int H_BACK         = 48;
    localparam int H_VIS          = 16;
    localparam int V_VIS          = 4;
    localparam int V_FRONT        = 1;
    localparam int V_SYNC         = 1;
    localparam int V_BACK         = 2;
    localparam bit H_POL          = 1'b0;     // active low syncs
    localparam bit V_POL          = 1'b0;
    localparam int H_TOTAL        = H_FRONT + H_SYNC + H_BACK + H_VIS;
    localparam int V_TOTAL        = V_VIS + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 200;
    localparam int VRAM_WORDS     = 64;

    // what run_frame checks on each displayed pixel
    localparam int MODE_NONE = 0;
    localparam int MODE_4BPP = 1;
    localparam int MODE_8BPP = 2;
    localparam int MODE_FLAT = 3;

    logic       clk;
    logic       reset_i;
    logic       enable_i;
    logic       reg_wr_i;
    reg_num_t   reg_num_i;
    vram_word_t reg_data_i;
    vram_word_t reg_data_o;
    logic       vram_req_o;
    vram_word_t vram_addr_o;
    logic       vram_ack_i;
    vram_word_t vram_data_i;
    logic [7:0] pal_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;
    logic       vsync_intr_o;
    logic       vline_intr_o;

    vram_word_t vram [VRAM_WORDS];
    integer     seed;
    int         ack_delay;
    int         cycle_count;
    int         frame_mark;                   // cycle_count at the last vsync interrupt seen
    int         error_count;
    int         checks_run;

    // per-frame results filled in by run_frame
    int de_cycles;
    int hs_pulses;
    int vs_cycles;
    int vsync_pulses;
    int vline_pulses;
    int req_rises;

    video_gen_top #(
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK), .H_VISIBLE(H_VIS),
        .V_VISIBLE(V_VIS), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_POL), .V_SYNC_POL(V_POL), .FIFO_DEPTH(8)
    ) dut_i (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .reg_wr_i(reg_wr_i),
        .reg_num_i(reg_num_i), .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .vram_req_o(vram_req_o), .vram_addr_o(vram_addr_o), .vram_ack_i(vram_ack_i),
        .vram_data_i(vram_data_i), .pal_index_o(pal_index_o), .hsync_o(hsync_o),
        .vsync_o(vsync_o), .dv_de_o(dv_de_o), .vsync_intr_o(vsync_intr_o),
        .vline_intr_o(vline_intr_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    // VRAM responder, acks after 1 to 3 cycles and releases once req falls
    always @(negedge clk) begin
        if (reset_i) begin
            vram_ack_i <= 1'b0;
            ack_delay = 0;
        end else if (vram_ack_i) begin
            if (!vram_req_o) begin
                vram_ack_i <= 1'b0;
            end
        end else if (vram_req_o) begin
            if (ack_delay == 0) begin
                ack_delay = 1 + int'($unsigned($random(seed)) % 3);
            end
            ack_delay = ack_delay - 1;
            if (ack_delay == 0) begin
                vram_ack_i  <= 1'b1;
                vram_data_i <= vram[vram_addr_o % VRAM_WORDS];
            end
        end
    end

    task automatic check_word(input string name, input vram_word_t exp, input vram_word_t act);
        checks_run++;
        if (act !== exp) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks_run++;
        if (act !== exp) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks_run++;
        if (act != exp) begin
            error_count++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic vram_word_t gfxctrl_word(input logic [7:0] base, input logic plane_off,
                                                input bpp_t bpp);
        return {base, plane_off, 1'b0, bpp, 4'h0};
    endfunction

    // called on a falling edge, returns on the next one
    task automatic write_reg(input reg_num_t num, input vram_word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i   = 1'b0;
    endtask

    task automatic read_reg(input reg_num_t num, output vram_word_t data);
        reg_num_i = num;
        @(negedge clk);
        data = reg_data_o;
    endtask

    task automatic wait_frame_mark();
        @(negedge clk);
        while (vsync_intr_o !== 1'b1) begin
            @(negedge clk);
        end
        frame_mark = cycle_count;
    endtask

    // samples every cycle up to the end of the current frame period after frame_mark
    task automatic run_frame(input string name, input int mode, input vram_word_t start,
                             input vram_word_t width, input logic [7:0] base);
        int         hs_run;
        int         line;
        int         pix;
        logic       req_prev;
        vram_word_t word;
        logic [7:0] exp_pix;
        de_cycles    = 0;
        hs_pulses    = 0;
        vs_cycles    = 0;
        vsync_pulses = 0;
        vline_pulses = 0;
        req_rises    = 0;
        hs_run       = 0;
        req_prev     = vram_req_o;
        do begin
            @(negedge clk);
            if (dv_de_o) begin
                line = de_cycles / H_VIS;
                pix  = de_cycles % H_VIS;
                if (mode == MODE_4BPP) begin
                    word    = vram[(start + width * line + pix / 4) % VRAM_WORDS];
                    exp_pix = {base[7:4], 4'(word >> (4 * (3 - pix % 4)))};
                end else if (mode == MODE_8BPP) begin
                    word    = vram[(start + width * line + pix / 2) % VRAM_WORDS];
                    exp_pix = 8'(word >> (8 * (1 - pix % 2)));
                end else begin
                    exp_pix = base;
                end
                if (mode != MODE_NONE) begin
                    check_index(name, exp_pix, pal_index_o);
                end
                de_cycles++;
            end
            if (hsync_o == H_POL) begin
                hs_run++;
            end else if (hs_run > 0) begin
                check_count({name, " hsync width"}, H_SYNC, hs_run);
                hs_pulses++;
                hs_run = 0;
            end
            if (vsync_o == V_POL) vs_cycles++;
            if (vsync_intr_o) vsync_pulses++;
            if (vline_intr_o) vline_pulses++;
            if (vram_req_o && !req_prev) req_rises++;
            req_prev = vram_req_o;
        end while ((cycle_count - frame_mark) % FRAME_CYCLES != 0);
    endtask

    task automatic test_reg_readback();
        vram_word_t rd;
        write_reg(REG_DISPSTART, 16'h0123);
        write_reg(REG_DISPWIDTH, 16'h0004);
        write_reg(REG_GFXCTRL, gfxctrl_word(8'hA0, 1'b0, BPP_4));
        write_reg(REG_LINEINTR, 16'h8002);
        read_reg(REG_DISPSTART, rd);
        check_word("readback DISPSTART", 16'h0123, rd);
        read_reg(REG_DISPWIDTH, rd);
        check_word("readback DISPWIDTH", 16'h0004, rd);
        read_reg(REG_GFXCTRL, rd);
        check_word("readback GFXCTRL", 16'hA020, rd);
        read_reg(REG_LINEINTR, rd);
        check_word("readback LINEINTR", 16'h8002, rd);
        read_reg(REG_R_WIDTH, rd);
        check_word("readback R_WIDTH", 16'd16, rd);
        read_reg(REG_R_HEIGHT, rd);
        check_word("readback R_HEIGHT", 16'd4, rd);
    endtask

    task automatic test_sync_counts();
        run_frame("sync", MODE_NONE, '0, '0, '0);
        check_count("sync de cycles", H_VIS * V_VIS, de_cycles);
        check_count("sync hsync pulses", V_TOTAL, hs_pulses);
        check_count("sync vsync cycles", V_SYNC * H_TOTAL, vs_cycles);
    endtask

    task automatic test_pixels_4bpp();
        enable_i = 1'b1;
        write_reg(REG_GFXCTRL, gfxctrl_word(8'hA0, 1'b0, BPP_4));
        write_reg(REG_DISPSTART, 16'd0);
        write_reg(REG_DISPWIDTH, 16'd4);
        run_frame("4bpp pixel", MODE_4BPP, 16'd0, 16'd4, 8'hA0);
        check_count("4bpp pixel count", H_VIS * V_VIS, de_cycles);
    endtask

    task automatic test_pixels_8bpp();
        write_reg(REG_GFXCTRL, gfxctrl_word(8'h30, 1'b0, BPP_8));
        write_reg(REG_DISPSTART, 16'd8);
        write_reg(REG_DISPWIDTH, 16'd10);
        run_frame("8bpp pixel", MODE_8BPP, 16'd8, 16'd10, 8'h30);
        check_count("8bpp pixel count", H_VIS * V_VIS, de_cycles);
    endtask

    task automatic test_plane_and_enable();
        write_reg(REG_GFXCTRL, gfxctrl_word(8'h5C, 1'b1, BPP_4));
        run_frame("plane off pixel", MODE_FLAT, '0, '0, 8'h5C);
        check_count("plane off pixel count", H_VIS * V_VIS, de_cycles);
        check_count("plane off requests", 0, req_rises);
        enable_i = 1'b0;
        run_frame("video off", MODE_NONE, '0, '0, '0);
        check_count("video off de cycles", 0, de_cycles);
        enable_i = 1'b1;
    endtask

    task automatic test_interrupts();
        write_reg(REG_LINEINTR, 16'h8002);  // line 2, enabled
        run_frame("intr on", MODE_NONE, '0, '0, '0);
        check_count("intr on vline pulses", 1, vline_pulses);
        check_count("intr on vsync pulses", 1, vsync_pulses);
        write_reg(REG_LINEINTR, 16'h0002);
        run_frame("intr off", MODE_NONE, '0, '0, '0);
        check_count("intr off vline pulses", 0, vline_pulses);
        check_count("intr off vsync pulses", 1, vsync_pulses);
    endtask

    initial begin
        error_count = 0;
        checks_run  = 0;
        ack_delay   = 0;
        frame_mark  = 0;
        seed        = 32'he9ae_3e70;
        reset_i     = 1'b1;
        enable_i    = 1'b1;
        reg_wr_i    = 1'b0;
        reg_num_i   = REG_DISPSTART;
        reg_data_i  = '0;
        vram_ack_i  = 1'b0;
        vram_data_i = '0;
        for (int i = 0; i < VRAM_WORDS; i++) begin
            vram[i] = vram_word_t'($random(seed));
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        test_reg_readback();
        wait_frame_mark();                  // align on the end of a frame's visible lines
        test_sync_counts();
        test_pixels_4bpp();
        test_pixels_8bpp();
        test_plane_and_enable();
        test_interrupts();

        $display("checks run: %0d, errors: %0d", checks_run, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
design/video_pkg.sv
design/video_timing.sv
design/video_regs.sv
design/vram_fetch.sv
design/line_word_fifo.sv
design/pixel_serializer.sv
design/video_gen_top.sv
verif/video_gen_tb.sv
